// File: Bender.yml
package:
  name: tenyr_system

sources:
  - tenyrPkg.sv
  - wbBus.sv
  - regFile.sv
  - insnDecode.sv
  - execUnit.sv
  - tenyrCore.sv
  - busArbiter.sv
  - sharedRam.sv
  - tenyrSystem.sv
  - target: simulation
    files:
      - tbClock.sv
      - tenyrSystemTb.sv

// File: busArbiter.sv
`timescale 1ns/1ps

module busArbiter #(
    parameter int addrWidth = 10
) (
    input  logic clk,
    input  logic reset_n,
    wbBus.slave  fetchBus,
    wbBus.slave  dataBus,
    wbBus.slave  hostBus,
    wbBus.master ramBus
);

    logic [2:0]      req;
    logic [1:0]      pick, sel, grant, last;
    logic            busy, anyReq;
    logic            selCyc, selStb, selWe;
    logic [31:0]     selAdr;
    tenyrPkg::word_t selDatW;

    assign req = {hostBus.cyc, dataBus.cyc, fetchBus.cyc};

    // first requester after the last one served.
    always_comb begin
        int cand;
        pick   = last;
        anyReq = 1'b0;
        for (int i = 1; i <= 3; i++) begin
            cand = (int'(last) + i) % 3;
            if (req[cand] && !anyReq) begin
                pick   = 2'(cand);
                anyReq = 1'b1;
            end
        end
    end

    assign sel = busy ? grant : pick;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            grant <= 2'd0;
            last  <= 2'd2; // fetch goes first.
        end else if (busy && ramBus.ack) begin
            busy <= 1'b0;
            last <= grant;
        end else if (!busy && anyReq) begin
            busy  <= 1'b1;
            grant <= pick;
        end
    end

    always_comb begin
        case (sel)
            2'd1: begin
                {selCyc, selStb, selWe} = {dataBus.cyc, dataBus.stb, dataBus.we};
                selAdr  = dataBus.adr;
                selDatW = dataBus.datW;
            end
            2'd2: begin
                {selCyc, selStb, selWe} = {hostBus.cyc, hostBus.stb, hostBus.we};
                selAdr  = hostBus.adr;
                selDatW = hostBus.datW;
            end
            default: begin
                {selCyc, selStb, selWe} = {fetchBus.cyc, fetchBus.stb, fetchBus.we};
                selAdr  = fetchBus.adr;
                selDatW = fetchBus.datW;
            end
        endcase
    end

    assign ramBus.cyc  = selCyc;
    assign ramBus.stb  = selStb;
    assign ramBus.we   = selWe;
    assign ramBus.adr  = {{(32 - addrWidth){1'b0}}, selAdr[addrWidth-1:0]};
    assign ramBus.datW = selDatW;

    // only the granted master sees the reply.
    assign fetchBus.ack  = ramBus.ack && (sel == 2'd0);
    assign dataBus.ack   = ramBus.ack && (sel == 2'd1);
    assign hostBus.ack   = ramBus.ack && (sel == 2'd2);
    assign fetchBus.datR = (sel == 2'd0) ? ramBus.datR : '0;
    assign dataBus.datR  = (sel == 2'd1) ? ramBus.datR : '0;
    assign hostBus.datR  = (sel == 2'd2) ? ramBus.datR : '0;

endmodule

// File: execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  logic             clk,
    input  logic             start,
    input  tenyrPkg::aluOp_t op,
    input  tenyrPkg::word_t  valA,
    input  tenyrPkg::word_t  valB,
    input  tenyrPkg::word_t  valC,
    output logic             done,
    output tenyrPkg::word_t  result
);

    tenyrPkg::aluOp_t rOp;
    tenyrPkg::word_t  rA, rB, rC;
    tenyrPkg::word_t  opNext, opRes, rC2, sum;
    logic             v1, v2, v3;

    always_comb begin
        case (rOp)
            tenyrPkg::opOr:   opNext = rA | rB;
            tenyrPkg::opAnd:  opNext = rA & rB;
            tenyrPkg::opXor:  opNext = rA ^ rB;
            tenyrPkg::opSra:  opNext = rA >>> rB;
            tenyrPkg::opAdd:  opNext = rA + rB;
            tenyrPkg::opMul:  opNext = rA * rB;
            tenyrPkg::opEq:   opNext = {32{rA == rB}};
            tenyrPkg::opLt:   opNext = {32{rA < rB}};
            tenyrPkg::opOrn:  opNext = rA | ~rB;
            tenyrPkg::opAndn: opNext = rA & ~rB;
            tenyrPkg::opPack: opNext = {rA[19:0], rB[11:0]};
            tenyrPkg::opSrl:  opNext = rA >> rB;
            tenyrPkg::opSub:  opNext = rA - rB;
            tenyrPkg::opShl:  opNext = rA << rB;
            tenyrPkg::opTest: opNext = {32{(rA & (32'sd1 << rB)) != '0}};
            default:          opNext = {32{rA >= rB}};
        endcase
    end

    // valid bits shift alongside the data.
    always_ff @(posedge clk) begin
        v1   <= start;
        v2   <= v1;
        v3   <= v2;
        done <= v3;
    end

    always_ff @(posedge clk) begin
        rOp    <= op;     // stage 1.
        rA     <= valA;
        rB     <= valB;
        rC     <= valC;
        opRes  <= opNext; // stage 2.
        rC2    <= rC;
        sum    <= opRes + rC2; // stage 3.
        result <= sum;
    end

endmodule

// File: insnDecode.sv
`timescale 1ns/1ps

module insnDecode (
    input  tenyrPkg::insn_t   insn,
    input  tenyrPkg::word_t   valX,
    input  tenyrPkg::word_t   valY,
    output tenyrPkg::regIdx_t idxZ,
    output tenyrPkg::regIdx_t idxX,
    output tenyrPkg::regIdx_t idxY,
    output tenyrPkg::aluOp_t  op,
    output tenyrPkg::word_t   valA,
    output tenyrPkg::word_t   valB,
    output tenyrPkg::word_t   valC,
    output logic              storing,
    output logic              loading,
    output logic              derefRhs,
    output logic              branching
);

    tenyrPkg::word_t valI;
    logic [1:0]      deref;

    assign deref = insn.alu.deref;
    assign idxZ  = insn.alu.z;
    assign idxX  = insn.alu.x;

    always_comb begin
        if (insn.alu.kind == tenyrPkg::kindImm) begin
            idxY = '0;
            op   = tenyrPkg::opOr; // X | 0 + I.
            valI = {{12{insn.imm.imm[19]}}, insn.imm.imm};
        end else begin
            idxY = insn.alu.y;
            op   = insn.alu.op;
            valI = {{20{insn.alu.imm[11]}}, insn.alu.imm};
        end
    end

    // operand order by kind.
    always_comb begin
        case (insn.alu.kind)
            tenyrPkg::kindXIY: begin valA = valX; valB = valI; valC = valY; end
            tenyrPkg::kindIXY: begin valA = valI; valB = valX; valC = valY; end
            default:           begin valA = valX; valB = valY; valC = valI; end // XYI order also serves the immediate load.
        endcase
    end

    assign storing   = ^deref;
    assign loading   = &deref;
    assign derefRhs  = deref[0]; // rhs is the address, or the load goes to Z.
    assign branching = (idxZ == tenyrPkg::regP) && !storing;

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  tenyrPkg::regIdx_t rdIdxX,
    input  tenyrPkg::regIdx_t rdIdxY,
    input  tenyrPkg::regIdx_t rdIdxZ,
    input  logic              wrEn,
    input  tenyrPkg::word_t   wrData,
    input  tenyrPkg::word_t   nextPc,
    output tenyrPkg::word_t   valX,
    output tenyrPkg::word_t   valY,
    output tenyrPkg::word_t   valZ
);

    tenyrPkg::word_t regs [1:14]; // r0 and r15 are not stored.

    assign valX = (rdIdxX == '0) ? '0 :
                  (rdIdxX == tenyrPkg::regP) ? nextPc : regs[rdIdxX];
    assign valY = (rdIdxY == '0) ? '0 :
                  (rdIdxY == tenyrPkg::regP) ? nextPc : regs[rdIdxY];
    assign valZ = (rdIdxZ == '0) ? '0 :
                  (rdIdxZ == tenyrPkg::regP) ? nextPc : regs[rdIdxZ];

    // a write to r15 is taken by the core as a branch.
    always_ff @(posedge clk) begin
        if (wrEn && rdIdxZ != '0 && rdIdxZ != tenyrPkg::regP) begin
            regs[rdIdxZ] <= wrData;
        end
    end

endmodule

// File: sharedRam.sv
`timescale 1ns/1ps

module sharedRam #(
    parameter int addrWidth = 10
) (
    input logic clk,
    input logic reset_n,
    wbBus.slave bus
);

    tenyrPkg::word_t      mem [0:2**addrWidth-1];
    tenyrPkg::word_t      rdData;
    logic [addrWidth-1:0] index;
    logic                 access, ackQ;

    assign index  = bus.adr[addrWidth-1:0];
    assign access = bus.cyc && bus.stb && !ackQ; // one ack per access.

    always_ff @(posedge clk) begin
        if (!reset_n) ackQ <= 1'b0;
        else          ackQ <= access;
    end

    always_ff @(posedge clk) begin
        if (access && bus.we) mem[index] <= bus.datW;
        rdData <= mem[index];
    end

    assign bus.ack  = ackQ;
    assign bus.datR = rdData;

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    initial begin
        reset_n = 1'b0;
        repeat (resetCycles) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

// File: tenyrCore.sv
`timescale 1ns/1ps

module tenyrCore #(
    parameter logic [31:0] resetVector = 32'd0
) (
    input  logic clk,
    input  logic reset_n,
    input  logic halt,
    wbBus.master fetchBus,
    wbBus.master dataBus
);

    localparam logic [2:0] sIdle   = 3'd0;
    localparam logic [2:0] sFetch  = 3'd1;
    localparam logic [2:0] sDecode = 3'd2;
    localparam logic [2:0] sExec   = 3'd3;
    localparam logic [2:0] sMem    = 3'd4;
    localparam logic [2:0] sWrite  = 3'd5;

    logic [2:0]        state;
    tenyrPkg::insn_t   insn;
    tenyrPkg::word_t   pc, nextPc, rhsReg, loadData, nextZ;
    tenyrPkg::word_t   valX, valY, valZ, valA, valB, valC, result;
    tenyrPkg::regIdx_t idxX, idxY, idxZ;
    tenyrPkg::aluOp_t  op;
    logic              storing, loading, derefRhs, branching;
    logic              execStart, execDone, wrEn;

    // ==============================
    // sequencer
    // ==============================

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= sIdle;
            pc    <= resetVector;
        end else begin
            case (state)
                sIdle:   if (!halt) state <= sFetch;
                sFetch:  if (fetchBus.ack) state <= sDecode;
                sDecode: state <= sExec;
                sExec: begin
                    if (execDone) state <= (loading || storing) ? sMem : sWrite;
                end
                sMem:    if (dataBus.ack) state <= sWrite;
                sWrite: begin
                    pc    <= branching ? nextZ : nextPc;
                    state <= sIdle; // halt is sampled there.
                end
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sFetch && fetchBus.ack) begin
            insn   <= fetchBus.datR;
            nextPc <= pc + 1;
        end
        if (state == sExec && execDone) rhsReg <= result;
        if (state == sMem && dataBus.ack) loadData <= dataBus.datR;
    end

    assign execStart = (state == sDecode);
    assign wrEn      = (state == sWrite) && !storing;
    assign nextZ     = derefRhs ? loadData : rhsReg;

    // ==============================
    // bus masters
    // ==============================

    assign fetchBus.cyc  = (state == sFetch);
    assign fetchBus.stb  = (state == sFetch);
    assign fetchBus.we   = 1'b0;
    assign fetchBus.adr  = pc;
    assign fetchBus.datW = '0;

    assign dataBus.cyc  = (state == sMem);
    assign dataBus.stb  = (state == sMem);
    assign dataBus.we   = (state == sMem) && storing;
    assign dataBus.adr  = derefRhs ? rhsReg : valZ;
    assign dataBus.datW = derefRhs ? valZ : rhsReg;

    regFile u_regFile (
        .clk    (clk),
        .rdIdxX (idxX),
        .rdIdxY (idxY),
        .rdIdxZ (idxZ),
        .wrEn   (wrEn),
        .wrData (nextZ),
        .nextPc (nextPc),
        .valX   (valX),
        .valY   (valY),
        .valZ   (valZ)
    );

    insnDecode u_insnDecode (
        .insn      (insn),
        .valX      (valX),
        .valY      (valY),
        .idxZ      (idxZ),
        .idxX      (idxX),
        .idxY      (idxY),
        .op        (op),
        .valA      (valA),
        .valB      (valB),
        .valC      (valC),
        .storing   (storing),
        .loading   (loading),
        .derefRhs  (derefRhs),
        .branching (branching)
    );

    execUnit u_execUnit (
        .clk    (clk),
        .start  (execStart),
        .op     (op),
        .valA   (valA),
        .valB   (valB),
        .valC   (valC),
        .done   (execDone),
        .result (result)
    );

endmodule

// File: tenyrPkg.sv
package tenyrPkg;

    // ==============================
    // bus and register words
    // ==============================

    typedef logic signed [31:0] word_t;
    typedef logic [3:0] regIdx_t;

    localparam regIdx_t regP = 4'd15; // program counter.

    // ==============================
    // operator and kind codes
    // ==============================

    typedef enum logic [3:0] {
        opOr, opAnd, opXor, opSra,
        opAdd, opMul, opEq, opLt,
        opOrn, opAndn, opPack, opSrl,
        opSub, opShl, opTest, opGe
    } aluOp_t;

    typedef enum logic [1:0] {kindXYI, kindXIY, kindIXY, kindImm} insnKind_t;

    // ==============================
    // instruction word
    // ==============================

    typedef struct packed {
        insnKind_t  kind;
        logic [1:0] deref;
        regIdx_t    z;
        regIdx_t    x;
        regIdx_t    y;
        aluOp_t     op;
        logic [11:0] imm;
    } aluView_t;

    typedef struct packed {
        insnKind_t  kind;
        logic [1:0] deref;
        regIdx_t    z;
        regIdx_t    x;
        logic [19:0] imm; // immediate load only.
    } immView_t;

    typedef union packed {
        aluView_t alu;
        immView_t imm;
    } insn_t;

endpackage

// File: tenyrSystem.f
tenyrPkg.sv
wbBus.sv
regFile.sv
insnDecode.sv
execUnit.sv
tenyrCore.sv
busArbiter.sv
sharedRam.sv
tenyrSystem.sv
tbClock.sv
tenyrSystemTb.sv

// File: tenyrSystem.sv
`timescale 1ns/1ps

module tenyrSystem #(
    parameter int          addrWidth   = 10,
    parameter logic [31:0] resetVector = 32'd0
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            halt,
    input  logic            hostCyc,
    input  logic            hostStb,
    input  logic            hostWe,
    input  logic [31:0]     hostAdr,
    input  tenyrPkg::word_t hostDatW,
    output tenyrPkg::word_t hostDatR,
    output logic            hostAck
);

    wbBus fetchBus ();
    wbBus dataBus ();
    wbBus hostBus ();
    wbBus ramBus ();

    // host side as a wishbone master.
    assign hostBus.cyc  = hostCyc;
    assign hostBus.stb  = hostStb;
    assign hostBus.we   = hostWe;
    assign hostBus.adr  = hostAdr;
    assign hostBus.datW = hostDatW;
    assign hostDatR     = hostBus.datR;
    assign hostAck      = hostBus.ack;

    tenyrCore #(.resetVector(resetVector)) u_core (
        .clk      (clk),
        .reset_n  (reset_n),
        .halt     (halt),
        .fetchBus (fetchBus),
        .dataBus  (dataBus)
    );

    busArbiter #(.addrWidth(addrWidth)) u_arbiter (
        .clk      (clk),
        .reset_n  (reset_n),
        .fetchBus (fetchBus),
        .dataBus  (dataBus),
        .hostBus  (hostBus),
        .ramBus   (ramBus)
    );

    sharedRam #(.addrWidth(addrWidth)) u_ram (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (ramBus)
    );

endmodule

// File: tenyrSystemTb.sv
`timescale 1ns/1ps

module tenyrSystemTb;

    localparam int addrWidth      = 10;
    localparam int memWords       = 2 ** addrWidth;
    localparam int hostBase       = 'h200; // words the core never touches.
    localparam int dumpBase       = 'h300;
    localparam int dataBase       = 'h380;
    localparam int flagAddr       = 'h3f0;
    localparam int cntAddr        = 'h3f1;
    localparam int totalInsns     = 600;   // all runs, rounded up.
    localparam int hostOps        = 800;
    localparam int watchdogCycles = totalInsns * 40 + hostOps * 8 + 500;

    logic            clk, reset_n, halt;
    logic            hostCyc, hostStb, hostWe, hostAck;
    logic [31:0]     hostAdr;
    tenyrPkg::word_t hostDatW, hostDatR;

    tenyrPkg::word_t mReg [0:15];
    tenyrPkg::word_t mMem [0:memWords-1];
    tenyrPkg::word_t mPc;
    tenyrPkg::insn_t prog [$];
    logic [31:0]     lfsr;
    int              parkPc, errors, checks;

    tbClock u_clock (.clk(clk), .reset_n(reset_n));

    tenyrSystem #(.addrWidth(addrWidth), .resetVector(32'd0)) u_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .halt     (halt),
        .hostCyc  (hostCyc),
        .hostStb  (hostStb),
        .hostWe   (hostWe),
        .hostAdr  (hostAdr),
        .hostDatW (hostDatW),
        .hostDatR (hostDatR),
        .hostAck  (hostAck)
    );

    // ==============================
    // random numbers and checks
    // ==============================

    function automatic logic lfsrBit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32 + x^22 + x^2 + x + 1.
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsrBit()};
        return v;
    endfunction

    task automatic checkWord(input tenyrPkg::word_t got, input tenyrPkg::word_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkInsn(input tenyrPkg::insn_t got, input tenyrPkg::insn_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s read %h (kind %0d), expected %h (kind %0d)",
                     $time, what, got, got.alu.kind, exp, exp.alu.kind);
        end
    endtask

    // ==============================
    // host port
    // ==============================

    task automatic waitAck(output tenyrPkg::word_t data);
        @(negedge clk);
        while (hostAck !== 1'b1) @(negedge clk);
        data = hostDatR;
        @(posedge clk);
        hostCyc <= 1'b0;
        hostStb <= 1'b0;
        hostWe  <= 1'b0;
    endtask

    task automatic hostWrite(input int addr, input tenyrPkg::word_t data);
        tenyrPkg::word_t unused;
        @(posedge clk);
        hostCyc  <= 1'b1;
        hostStb  <= 1'b1;
        hostWe   <= 1'b1;
        hostAdr  <= addr;
        hostDatW <= data;
        waitAck(unused);
    endtask

    task automatic hostRead(input int addr, output tenyrPkg::word_t data);
        @(posedge clk);
        hostCyc <= 1'b1;
        hostStb <= 1'b1;
        hostWe  <= 1'b0;
        hostAdr <= addr;
        waitAck(data);
    endtask

    task automatic loadWord(input int addr, input tenyrPkg::word_t data);
        hostWrite(addr, data);
        mMem[addr] = data;
    endtask

    task automatic checkRegion(input int base, input int n, input string what);
        tenyrPkg::word_t got;
        for (int k = 0; k < n; k++) begin
            hostRead(base + k, got);
            checkWord(got, mMem[base + k], $sformatf("%s word %0d", what, k));
        end
    endtask

    // ==============================
    // instruction words
    // ==============================

    function automatic tenyrPkg::insn_t immInsn(input logic [1:0] deref,
            input tenyrPkg::regIdx_t z, input tenyrPkg::regIdx_t x, input logic [19:0] imm);
        tenyrPkg::insn_t w;
        w.imm.kind  = tenyrPkg::kindImm;
        w.imm.deref = deref;
        w.imm.z     = z;
        w.imm.x     = x;
        w.imm.imm   = imm;
        return w;
    endfunction

    function automatic tenyrPkg::insn_t aluInsn(input tenyrPkg::insnKind_t kind,
            input logic [1:0] deref, input tenyrPkg::regIdx_t z, input tenyrPkg::regIdx_t x,
            input tenyrPkg::regIdx_t y, input tenyrPkg::aluOp_t op, input logic [11:0] imm);
        tenyrPkg::insn_t w;
        w.alu.kind  = kind;
        w.alu.deref = deref;
        w.alu.z     = z;
        w.alu.x     = x;
        w.alu.y     = y;
        w.alu.op    = op;
        w.alu.imm   = imm;
        return w;
    endfunction

    task automatic pushDump();
        for (int r = 1; r <= 14; r++) prog.push_back(immInsn(2'b01, r, 0, dumpBase + r));
    endtask

    // ==============================
    // reference model
    // ==============================

    function automatic tenyrPkg::word_t regRead(input tenyrPkg::regIdx_t idx,
                                                input tenyrPkg::word_t pcNext);
        if (idx == 0) return '0;
        if (idx == tenyrPkg::regP) return pcNext;
        return mReg[idx];
    endfunction

    function automatic tenyrPkg::word_t applyOp(input tenyrPkg::aluOp_t op,
                                                input tenyrPkg::word_t a, input tenyrPkg::word_t b);
        tenyrPkg::word_t r;
        logic [31:0]     ua, ub;
        logic            big;
        ua  = a;
        ub  = b;
        big = ub > 32'd31; // shift counts past the word width.
        case (op)
            tenyrPkg::opOr:   r = a | b;
            tenyrPkg::opAnd:  r = a & b;
            tenyrPkg::opXor:  r = a ^ b;
            tenyrPkg::opSra: begin
                if (big) r = {32{a[31]}};
                else     r = a >>> ub[4:0];
            end
            tenyrPkg::opAdd:  r = a + b;
            tenyrPkg::opMul:  r = a * b;
            tenyrPkg::opEq:   r = (a == b) ? -32'sd1 : 32'sd0;
            tenyrPkg::opLt:   r = (a < b) ? -32'sd1 : 32'sd0;
            tenyrPkg::opOrn:  r = a | ~b;
            tenyrPkg::opAndn: r = a & ~b;
            tenyrPkg::opPack: r = {ua[19:0], ub[11:0]};
            tenyrPkg::opSrl:  r = big ? 32'd0 : ua >> ub[4:0];
            tenyrPkg::opSub:  r = a - b;
            tenyrPkg::opShl:  r = big ? 32'd0 : ua << ub[4:0];
            tenyrPkg::opTest: r = (!big && ua[ub[4:0]]) ? -32'sd1 : 32'sd0;
            default:          r = (a >= b) ? -32'sd1 : 32'sd0;
        endcase
        return r;
    endfunction

    task automatic modelStep();
        tenyrPkg::insn_t    in;
        tenyrPkg::word_t    pcNext, x, y, i, a, b, c, rhs, zv, wb;
        tenyrPkg::aluOp_t   op;
        tenyrPkg::insnKind_t kind;
        in     = mMem[mPc[addrWidth-1:0]];
        kind   = in.alu.kind;
        pcNext = mPc + 1;
        x      = regRead(in.alu.x, pcNext);
        y      = regRead(in.alu.y, pcNext);
        zv     = regRead(in.alu.z, pcNext);
        op     = in.alu.op;
        i      = {{20{in.alu.imm[11]}}, in.alu.imm};
        if (kind == tenyrPkg::kindImm) begin
            op = tenyrPkg::opOr; // X | r0, plus the long immediate.
            i  = {{12{in.imm.imm[19]}}, in.imm.imm};
        end
        a = (kind == tenyrPkg::kindIXY) ? i : x;
        b = (kind == tenyrPkg::kindXYI) ? y : (kind == tenyrPkg::kindXIY) ? i :
            (kind == tenyrPkg::kindIXY) ? x : 32'sd0;
        c = (kind == tenyrPkg::kindXYI || kind == tenyrPkg::kindImm) ? i : y;
        rhs = applyOp(op, a, b) + c;
        mPc = pcNext;
        case (in.alu.deref)
            2'b01: mMem[rhs[addrWidth-1:0]] = zv; // [rhs] <- Z.
            2'b10: mMem[zv[addrWidth-1:0]] = rhs; // [Z] <- rhs.
            default: begin
                wb = in.alu.deref[0] ? mMem[rhs[addrWidth-1:0]] : rhs;
                if (in.alu.z == tenyrPkg::regP) mPc = wb;
                else if (in.alu.z != 0) mReg[in.alu.z] = wb;
            end
        endcase
    endtask

    // runs until an instruction branches to itself.
    task automatic runModel(input int start);
        tenyrPkg::word_t here;
        int              steps;
        mPc   = start;
        steps = 0;
        do begin
            here = mPc;
            modelStep();
            steps++;
        end while (mPc != here && steps < 2000);
        if (mPc != here) begin
            errors++;
            $display("The reference model never reached the closing loop at %0t", $time);
        end
    endtask

    task automatic runProgram(input tenyrPkg::word_t marker);
        tenyrPkg::word_t flag, probe;
        int              loopAddr, polls;
        prog.push_back(immInsn(2'b00, 1, 0, marker[19:0]));
        prog.push_back(immInsn(2'b01, 1, 0, flagAddr));
        loopAddr = parkPc + prog.size();
        prog.push_back(immInsn(2'b00, tenyrPkg::regP, 0, loopAddr));
        loadWord(flagAddr, '0);
        foreach (prog[k]) loadWord(parkPc + k, prog[k]);
        prog.delete();
        runModel(parkPc);
        @(posedge clk);
        halt  <= 1'b0;
        polls = 0;
        do begin
            hostRead(hostBase + polls % 16, probe); // competes with the core.
            checkWord(probe, mMem[hostBase + polls % 16], "host read while running");
            hostRead(flagAddr, flag);
            polls++;
        end while (flag !== marker);
        @(posedge clk);
        halt <= 1'b1;
        repeat (40) @(posedge clk); // let the last instruction drain.
        parkPc = loopAddr;
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial begin
        tenyrPkg::word_t got, v1, v2, v3;
        tenyrPkg::insn_t exp [0:15];
        logic [1:0]      deref;
        logic [19:0]     keep;
        int              loopStart;
        lfsr     = 32'h0e9326c3;
        errors   = 0;
        checks   = 0;
        parkPc   = 0;
        halt     = 1'b1;
        hostCyc  = 1'b0;
        hostStb  = 1'b0;
        hostWe   = 1'b0;
        hostAdr  = '0;
        hostDatW = '0;
        wait (reset_n === 1'b1);
        @(posedge clk);

        // host access before the first fetch.
        for (int k = 0; k < 16; k++) begin
            exp[k] = randBits(32);
            loadWord(hostBase + k, exp[k]);
        end
        for (int k = 0; k < 16; k++) begin
            hostRead(hostBase + k, got);
            checkInsn(got, exp[k], "host readback");
        end

        // operators.
        for (int r = 1; r <= 14; r++) prog.push_back(immInsn(2'b00, r, 0, randBits(20)));
        for (int k = 0; k < 64; k++) begin
            prog.push_back(aluInsn(tenyrPkg::insnKind_t'(randBits(2)), 2'b00,
                                   1 + randBits(8) % 14, randBits(8) % 15, randBits(8) % 15,
                                   tenyrPkg::aluOp_t'(k % 16),
                                   randBits(1) ? randBits(5) : randBits(12)));
        end
        pushDump();
        runProgram(32'd1);
        checkRegion(dumpBase + 1, 14, "operator dump");

        // loads and stores through the data base held in r14.
        for (int k = 0; k < 32; k++) loadWord(dataBase + k, randBits(32));
        prog.push_back(immInsn(2'b00, 14, 0, dataBase));
        for (int k = 0; k < 24; k++) begin
            deref = randBits(2);
            if (deref == 2'b10) begin
                prog.push_back(immInsn(2'b00, 13, 0, dataBase + randBits(5)));
                prog.push_back(immInsn(2'b10, 13, 1 + randBits(8) % 12, randBits(12)));
            end else begin
                prog.push_back(aluInsn(tenyrPkg::kindXYI, deref, 1 + randBits(8) % 12, 14, 0,
                                       tenyrPkg::opAdd, randBits(5)));
            end
        end
        pushDump();
        runProgram(32'd2);
        checkRegion(dumpBase + 1, 14, "load/store dump");
        checkRegion(dataBase, 32, "data region");

        // branch over a write that would corrupt r5.
        keep = randBits(20);
        prog.push_back(immInsn(2'b00, 5, 0, keep));
        prog.push_back(aluInsn(tenyrPkg::kindXYI, 2'b00, tenyrPkg::regP, tenyrPkg::regP, 0,
                               tenyrPkg::opAdd, 12'd1));
        prog.push_back(immInsn(2'b00, 5, 0, 20'h0bad0));
        pushDump();
        runProgram(32'd3);
        checkRegion(dumpBase + 1, 14, "branch dump");
        hostRead(dumpBase + 5, got);
        checkWord(got, {{12{keep[19]}}, keep}, "r5 after skipped write");

        // halt holds a running counter loop.
        loadWord(cntAddr, '0);
        loopStart = parkPc + 1;
        prog.push_back(immInsn(2'b00, 1, 0, 20'd0));
        prog.push_back(aluInsn(tenyrPkg::kindXYI, 2'b00, 1, 1, 0, tenyrPkg::opAdd, 12'd1));
        prog.push_back(immInsn(2'b01, 1, 0, cntAddr));
        prog.push_back(immInsn(2'b00, tenyrPkg::regP, 0, loopStart));
        foreach (prog[k]) loadWord(parkPc + k, prog[k]);
        prog.delete();
        @(posedge clk);
        halt <= 1'b0;
        do hostRead(cntAddr, v1); while (v1 === 32'sd0);
        @(posedge clk);
        halt <= 1'b1;
        repeat (40) @(posedge clk);
        hostRead(cntAddr, v1);
        repeat (100) @(posedge clk);
        hostRead(cntAddr, v2);
        checkWord(v2, v1, "counter while halted");
        @(posedge clk);
        halt <= 1'b0;
        repeat (100) @(posedge clk);
        hostRead(cntAddr, v3);
        checks++;
        if (!(v3 > v2)) begin
            errors++;
            $display("CHECK FAILED at %0t: counter read %0d after release, not above %0d",
                     $time, v3, v2);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog.
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: wbBus.sv
`timescale 1ns/1ps

// one word-wide wishbone classic link without byte lanes.
interface wbBus;

    logic            cyc;
    logic            stb;
    logic            we;
    logic [31:0]     adr;
    tenyrPkg::word_t datW;
    tenyrPkg::word_t datR;
    logic            ack;

    modport master (
        output cyc, stb, we, adr, datW,
        input  datR, ack
    );

    modport slave (
        input  cyc, stb, we, adr, datW,
        output datR, ack
    );

endinterface
